// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  - files:
      - common/cfgPkg.sv
      - common/uopPkg.sv
      - design/Dispatcher.sv
      - reservationStation/ReservationStation.sv
      - design/IntAlu.sv
      - design/ResultArbiter.sv
      - design/ExecCluster.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/ExecClusterTb.sv

// ==== common/cfgPkg.sv ====
package cfgPkg;

    // ==================================================
    // Datapath widths
    // ==================================================

    localparam int DATA_WIDTH = 32;    // Operand and result width.
    localparam int TAG_WIDTH = 6;      // Producer tag width.
    localparam int OPCODE_WIDTH = 6;

    // Shift amount is taken from the low bits of operand B.
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

    // ==================================================
    // Operands
    // ==================================================

    localparam int SRC_COUNT = 2;      // Register sources per micro-op.
    localparam int SRC_A = 0;
    localparam int SRC_B = 1;

    // Tag zero marks a source whose value is already present.
    localparam logic [TAG_WIDTH-1:0] TAG_READY = '0;

endpackage

// ==== common/uopPkg.sv ====
package uopPkg;

    // ==================================================
    // ALU operations
    // ==================================================

    typedef enum logic [cfgPkg::OPCODE_WIDTH-1:0] {
        ALU_ADD      = 6'd0,
        ALU_SUB      = 6'd1,
        ALU_AND      = 6'd2,
        ALU_OR       = 6'd3,
        ALU_XOR      = 6'd4,
        ALU_SLL      = 6'd5,
        ALU_SRL      = 6'd6,
        ALU_PASS_IMM = 6'd7    // Result is the immediate.
    } AluOp;

    // ==================================================
    // Reservation station slot
    // ==================================================

    // Sources are indexed by cfgPkg::SRC_A and cfgPkg::SRC_B.
    typedef struct packed {
        logic valid;
        AluOp opcode;
        logic [cfgPkg::TAG_WIDTH-1:0] tagDst;
        logic [cfgPkg::DATA_WIDTH-1:0] imm;
        logic [cfgPkg::SRC_COUNT-1:0][cfgPkg::DATA_WIDTH-1:0] srcVal;
        logic [cfgPkg::SRC_COUNT-1:0][cfgPkg::TAG_WIDTH-1:0] srcTag;    // Zero when present.
    } StationEntry;

endpackage

// ==== design/Dispatcher.sv ====
`timescale 1ns/10ps

module Dispatcher #(
    parameter int STATION_COUNT = 3,
    parameter int RESULT_BUS_COUNT = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic uopValid,
    input  uopPkg::AluOp uopOpcode,
    input  logic [cfgPkg::TAG_WIDTH-1:0] uopTagDst,
    input  logic [cfgPkg::DATA_WIDTH-1:0] uopImm,
    input  logic [cfgPkg::DATA_WIDTH-1:0] uopSrcA,
    input  logic [cfgPkg::TAG_WIDTH-1:0] uopTagA,
    input  logic [cfgPkg::DATA_WIDTH-1:0] uopSrcB,
    input  logic [cfgPkg::TAG_WIDTH-1:0] uopTagB,
    output logic stall,

    input  logic [STATION_COUNT-1:0] stationFull,

    input  logic [RESULT_BUS_COUNT-1:0] resultValid,
    input  logic [cfgPkg::TAG_WIDTH-1:0] resultTag [RESULT_BUS_COUNT],
    input  logic [cfgPkg::DATA_WIDTH-1:0] resultData [RESULT_BUS_COUNT],

    output logic enqValid,
    output logic [STATION_COUNT-1:0] enqSelect,
    output uopPkg::AluOp enqOpcode,
    output logic [cfgPkg::TAG_WIDTH-1:0] enqTagDst,
    output logic [cfgPkg::DATA_WIDTH-1:0] enqImm,
    output logic [cfgPkg::DATA_WIDTH-1:0] enqSrcA,
    output logic [cfgPkg::TAG_WIDTH-1:0] enqTagA,
    output logic [cfgPkg::DATA_WIDTH-1:0] enqSrcB,
    output logic [cfgPkg::TAG_WIDTH-1:0] enqTagB
);
    import cfgPkg::*;
    import uopPkg::*;

    logic heldValid;
    AluOp heldOpcode;
    logic [TAG_WIDTH-1:0] heldTagDst;
    logic [DATA_WIDTH-1:0] heldImm;
    logic [DATA_WIDTH-1:0] heldSrcA;
    logic [TAG_WIDTH-1:0] heldTagA;
    logic [DATA_WIDTH-1:0] heldSrcB;
    logic [TAG_WIDTH-1:0] heldTagB;
    logic [STATION_COUNT-1:0] freeMask;

    // Swap a pending tag for its value if it is on a result bus now.
    function automatic logic [TAG_WIDTH+DATA_WIDTH-1:0] snoop(
        input logic [TAG_WIDTH-1:0] tag,
        input logic [DATA_WIDTH-1:0] value
    );
        logic [TAG_WIDTH+DATA_WIDTH-1:0] operand;
        operand = {tag, value};
        for (int b = 0; b < RESULT_BUS_COUNT; b++) begin
            if (tag != TAG_READY && resultValid[b] && resultTag[b] == tag) begin
                operand = {TAG_READY, resultData[b]};
            end
        end
        return operand;
    endfunction

    // Lowest-indexed station with room.
    assign freeMask = ~stationFull;
    assign enqSelect = freeMask & (~freeMask + 1'b1);
    assign enqValid = heldValid && (|freeMask);
    assign stall = heldValid && !(|freeMask);

    assign enqOpcode = heldOpcode;
    assign enqTagDst = heldTagDst;
    assign enqImm = heldImm;

    always_comb begin
        {enqTagA, enqSrcA} = snoop(heldTagA, heldSrcA);
        {enqTagB, enqSrcB} = snoop(heldTagB, heldSrcB);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
        end else if (!stall) begin
            heldValid <= uopValid;    // Old entry leaves on this edge.
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            heldOpcode <= uopOpcode;
            heldTagDst <= uopTagDst;
            heldImm <= uopImm;
            {heldTagA, heldSrcA} <= snoop(uopTagA, uopSrcA);
            {heldTagB, heldSrcB} <= snoop(uopTagB, uopSrcB);
        end else begin
            // Keep snooping while blocked.
            {heldTagA, heldSrcA} <= {enqTagA, enqSrcA};
            {heldTagB, heldSrcB} <= {enqTagB, enqSrcB};
        end
    end

endmodule

// ==== design/ExecCluster.sv ====
`timescale 1ns/10ps

module ExecCluster #(
    parameter int QUEUE_SIZE = 4,
    parameter int STATION_COUNT = 3,
    parameter int RESULT_BUS_COUNT = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic uopValid,
    input  uopPkg::AluOp uopOpcode,
    input  logic [cfgPkg::TAG_WIDTH-1:0] uopTagDst,
    input  logic [cfgPkg::DATA_WIDTH-1:0] uopImm,
    input  logic [cfgPkg::DATA_WIDTH-1:0] uopSrcA,
    input  logic [cfgPkg::TAG_WIDTH-1:0] uopTagA,
    input  logic [cfgPkg::DATA_WIDTH-1:0] uopSrcB,
    input  logic [cfgPkg::TAG_WIDTH-1:0] uopTagB,
    output logic stall,

    output logic [RESULT_BUS_COUNT-1:0] resultValid,
    output logic [cfgPkg::TAG_WIDTH-1:0] resultTag [RESULT_BUS_COUNT],
    output logic [cfgPkg::DATA_WIDTH-1:0] resultData [RESULT_BUS_COUNT]
);
    import cfgPkg::*;
    import uopPkg::*;

    // Shared enqueue lines.
    logic enqValid;
    logic [STATION_COUNT-1:0] enqSelect;
    logic [STATION_COUNT-1:0] stationFull;
    AluOp enqOpcode;
    logic [TAG_WIDTH-1:0] enqTagDst;
    logic [DATA_WIDTH-1:0] enqImm;
    logic [DATA_WIDTH-1:0] enqSrcA;
    logic [TAG_WIDTH-1:0] enqTagA;
    logic [DATA_WIDTH-1:0] enqSrcB;
    logic [TAG_WIDTH-1:0] enqTagB;

    // ALU results towards the arbiter.
    logic [STATION_COUNT-1:0] doneValid;
    logic [STATION_COUNT-1:0] grant;
    logic [TAG_WIDTH-1:0] doneTag [STATION_COUNT];
    logic [DATA_WIDTH-1:0] doneData [STATION_COUNT];

    Dispatcher #(
        .STATION_COUNT(STATION_COUNT),
        .RESULT_BUS_COUNT(RESULT_BUS_COUNT)
    ) dispatcher (
        .clk, .rst,
        .uopValid, .uopOpcode, .uopTagDst, .uopImm,
        .uopSrcA, .uopTagA, .uopSrcB, .uopTagB, .stall,
        .stationFull,
        .resultValid, .resultTag, .resultData,
        .enqValid, .enqSelect, .enqOpcode, .enqTagDst, .enqImm,
        .enqSrcA, .enqTagA, .enqSrcB, .enqTagB
    );

    // ==================================================
    // Station and ALU pairs
    // ==================================================

    for (genvar i = 0; i < STATION_COUNT; i++) begin : gPair
        logic issueValid;
        AluOp issueOpcode;
        logic [DATA_WIDTH-1:0] issueA;
        logic [DATA_WIDTH-1:0] issueB;
        logic [DATA_WIDTH-1:0] issueImm;
        logic [TAG_WIDTH-1:0] issueTagDst;
        logic aluBusy;

        ReservationStation #(
            .QUEUE_SIZE(QUEUE_SIZE),
            .RESULT_BUS_COUNT(RESULT_BUS_COUNT)
        ) station (
            .clk, .rst,
            .enqValid, .enqSelected(enqSelect[i]),
            .enqOpcode, .enqTagDst, .enqImm,
            .enqSrcA, .enqTagA, .enqSrcB, .enqTagB,
            .resultValid, .resultTag, .resultData,
            .aluBusy, .full(stationFull[i]),
            .issueValid, .issueOpcode, .issueA, .issueB, .issueImm, .issueTagDst
        );

        IntAlu alu (
            .clk, .rst,
            .issueValid, .issueOpcode, .issueA, .issueB, .issueImm, .issueTagDst,
            .grant(grant[i]),
            .busy(aluBusy),
            .doneValid(doneValid[i]),
            .doneTag(doneTag[i]),
            .doneData(doneData[i])
        );
    end

    ResultArbiter #(
        .STATION_COUNT(STATION_COUNT),
        .RESULT_BUS_COUNT(RESULT_BUS_COUNT)
    ) arbiter (
        .clk, .rst,
        .doneValid, .doneTag, .doneData,
        .grant,
        .resultValid, .resultTag, .resultData
    );

endmodule

// ==== design/IntAlu.sv ====
`timescale 1ns/10ps

module IntAlu (
    input  logic clk,
    input  logic rst,

    input  logic issueValid,
    input  uopPkg::AluOp issueOpcode,
    input  logic [cfgPkg::DATA_WIDTH-1:0] issueA,
    input  logic [cfgPkg::DATA_WIDTH-1:0] issueB,
    input  logic [cfgPkg::DATA_WIDTH-1:0] issueImm,
    input  logic [cfgPkg::TAG_WIDTH-1:0] issueTagDst,
    input  logic grant,

    output logic busy,
    output logic doneValid,
    output logic [cfgPkg::TAG_WIDTH-1:0] doneTag,
    output logic [cfgPkg::DATA_WIDTH-1:0] doneData
);
    import cfgPkg::*;
    import uopPkg::*;

    logic [DATA_WIDTH-1:0] aluResult;

    always_comb begin
        case (issueOpcode)
            ALU_ADD:      aluResult = issueA + issueB;
            ALU_SUB:      aluResult = issueA - issueB;
            ALU_AND:      aluResult = issueA & issueB;
            ALU_OR:       aluResult = issueA | issueB;
            ALU_XOR:      aluResult = issueA ^ issueB;
            ALU_SLL:      aluResult = issueA << issueB[SHAMT_WIDTH-1:0];
            ALU_SRL:      aluResult = issueA >> issueB[SHAMT_WIDTH-1:0];
            ALU_PASS_IMM: aluResult = issueImm;
            default:      aluResult = '0;
        endcase
    end

    // A pending result frees up on its grant edge.
    assign busy = doneValid && !grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            doneValid <= 1'b0;
        end else if (!busy) begin
            doneValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && issueValid) begin
            doneData <= aluResult;
            doneTag <= issueTagDst;
        end
    end

endmodule

// ==== design/ResultArbiter.sv ====
`timescale 1ns/10ps

module ResultArbiter #(
    parameter int STATION_COUNT = 3,
    parameter int RESULT_BUS_COUNT = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic [STATION_COUNT-1:0] doneValid,
    input  logic [cfgPkg::TAG_WIDTH-1:0] doneTag [STATION_COUNT],
    input  logic [cfgPkg::DATA_WIDTH-1:0] doneData [STATION_COUNT],

    output logic [STATION_COUNT-1:0] grant,
    output logic [RESULT_BUS_COUNT-1:0] resultValid,
    output logic [cfgPkg::TAG_WIDTH-1:0] resultTag [RESULT_BUS_COUNT],
    output logic [cfgPkg::DATA_WIDTH-1:0] resultData [RESULT_BUS_COUNT]
);
    localparam int PTR_WIDTH = (STATION_COUNT > 1) ? $clog2(STATION_COUNT) : 1;

    logic [PTR_WIDTH-1:0] ptr;    // First ALU considered this cycle.

    // ==================================================
    // Grant and bus assignment
    // ==================================================

    always_comb begin
        int idx;
        int bus;
        grant = '0;
        resultValid = '0;
        for (int b = 0; b < RESULT_BUS_COUNT; b++) begin
            resultTag[b] = '0;
            resultData[b] = '0;
        end
        bus = 0;
        for (int k = 0; k < STATION_COUNT; k++) begin
            idx = int'(ptr) + k;
            if (idx >= STATION_COUNT) idx = idx - STATION_COUNT;    // Wrap.
            if (doneValid[idx] && bus < RESULT_BUS_COUNT) begin
                grant[idx] = 1'b1;
                resultValid[bus] = 1'b1;
                resultTag[bus] = doneTag[idx];
                resultData[bus] = doneData[idx];
                bus = bus + 1;
            end
        end
    end

    // Rotate by one ALU every cycle, loaded or not.
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (ptr == PTR_WIDTH'(STATION_COUNT - 1)) begin
            ptr <= '0;
        end else begin
            ptr <= ptr + 1'b1;
        end
    end

endmodule

// ==== dv/tbTasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ==================================================
// Reference model
// ==================================================

function automatic logic [DATA_WIDTH-1:0] expectedResult(
    input AluOp op,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b,
    input logic [DATA_WIDTH-1:0] imm
);
    logic [4:0] shamt;
    shamt = b[4:0];    // Low five bits only.
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_AND: return a & b;
        ALU_OR:  return a | b;
        ALU_XOR: return a ^ b;
        ALU_SLL: return a << shamt;
        ALU_SRL: return a >> shamt;
        default: return imm;
    endcase
endfunction

// A non-zero producer stands for its recorded result.
function automatic logic [DATA_WIDTH-1:0] sourceValue(
    input logic [TAG_WIDTH-1:0] prod,
    input logic [DATA_WIDTH-1:0] value
);
    return (prod != '0) ? expValue[prod] : value;
endfunction

function automatic logic [TAG_WIDTH-1:0] nextTag();
    lastTag = (lastTag == '1) ? TAG_WIDTH'(1) : lastTag + 1'b1;    // Zero is never handed out.
    return lastTag;
endfunction

function automatic bit anyPending();
    foreach (tagState[t]) begin
        if (tagState[t] == TAG_PENDING) return 1'b1;
    end
    return 1'b0;
endfunction

// ==================================================
// Stimulus and waits
// ==================================================

task automatic sendUop(
    input AluOp op,
    input logic [TAG_WIDTH-1:0] prodA,
    input logic [DATA_WIDTH-1:0] valA,
    input logic [TAG_WIDTH-1:0] prodB,
    input logic [DATA_WIDTH-1:0] valB,
    input bit timed,
    output logic [TAG_WIDTH-1:0] tag
);
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    int waited;
    bit accepted;
    a = sourceValue(prodA, valA);
    b = sourceValue(prodB, valB);
    tag = nextTag();
    uopImm = $urandom();
    expValue[tag] = expectedResult(op, a, b, uopImm);
    tagState[tag] = TAG_FREE;
    timedTag[tag] = timed;
    uopValid = 1'b1;
    uopOpcode = op;
    uopTagDst = tag;
    waited = 0;
    accepted = 1'b0;
    while (!accepted && waited < WAIT_LIMIT) begin
        // Producers still in flight go as tags, finished ones as values.
        uopTagA = (prodA != '0 && tagState[prodA] == TAG_PENDING) ? prodA : '0;
        uopSrcA = (uopTagA != '0) ? $urandom() : a;
        uopTagB = (prodB != '0 && tagState[prodB] == TAG_PENDING) ? prodB : '0;
        uopSrcB = (uopTagB != '0) ? $urandom() : b;
        @(posedge clk);
        accepted = !stall;
        waited++;
        #2;
    end
    uopValid = 1'b0;
    if (!accepted) begin
        timeoutErrors++;
        $display("Micro-op with tag %0d was never accepted", tag);
    end
endtask

task automatic waitForTag(input logic [TAG_WIDTH-1:0] tag);
    int waited;
    waited = 0;
    while (tagState[tag] != TAG_DONE && waited < WAIT_LIMIT) begin
        @(posedge clk);
        #2;
        waited++;
    end
    if (tagState[tag] != TAG_DONE) begin
        timeoutErrors++;
        $display("Timed out waiting for the result of tag %0d", tag);
    end
endtask

task automatic waitDrained();
    int waited;
    waited = 0;
    while (anyPending() && waited < WAIT_LIMIT) begin
        @(posedge clk);
        #2;
        waited++;
    end
    if (anyPending()) begin
        timeoutErrors++;
        $display("Timed out waiting for the cluster to drain");
    end
endtask

task automatic idleCycles(input int count);
    for (int i = 0; i < count; i++) begin
        @(posedge clk);
    end
    #2;
endtask

`endif

// ==== dv/ExecClusterTb.sv ====
`timescale 1ns/10ps

module ExecClusterTb;
    import cfgPkg::*;
    import uopPkg::*;

    localparam int QUEUE_SIZE = 4;
    localparam int STATION_COUNT = 3;
    localparam int RESULT_BUS_COUNT = 2;
    localparam int WAIT_LIMIT = 200;    // Cycles per wait.
    localparam int TAG_FREE = 0;
    localparam int TAG_PENDING = 1;
    localparam int TAG_DONE = 2;

    logic clk;
    logic rst;
    logic uopValid;
    AluOp uopOpcode;
    logic [TAG_WIDTH-1:0] uopTagDst;
    logic [DATA_WIDTH-1:0] uopImm;
    logic [DATA_WIDTH-1:0] uopSrcA;
    logic [TAG_WIDTH-1:0] uopTagA;
    logic [DATA_WIDTH-1:0] uopSrcB;
    logic [TAG_WIDTH-1:0] uopTagB;
    logic stall;
    logic [RESULT_BUS_COUNT-1:0] resultValid;
    logic [TAG_WIDTH-1:0] resultTag [RESULT_BUS_COUNT];
    logic [DATA_WIDTH-1:0] resultData [RESULT_BUS_COUNT];

    // Scoreboard, indexed by tag.
    logic [DATA_WIDTH-1:0] expValue [1 << TAG_WIDTH];
    int tagState [1 << TAG_WIDTH];
    int acceptCycle [1 << TAG_WIDTH];
    bit timedTag [1 << TAG_WIDTH];
    logic [TAG_WIDTH-1:0] lastTag = '0;
    int cycleCount = 0;
    int inFlight = 0;    // Accepted and not yet broadcast.
    bit firstAccepted = 1'b0;
    bit stallSeen = 1'b0;
    int valueErrors = 0;
    int protocolErrors = 0;
    int timeoutErrors = 0;

    ExecCluster #(
        .QUEUE_SIZE(QUEUE_SIZE),
        .STATION_COUNT(STATION_COUNT),
        .RESULT_BUS_COUNT(RESULT_BUS_COUNT)
    ) DUT (
        .clk, .rst,
        .uopValid, .uopOpcode, .uopTagDst, .uopImm,
        .uopSrcA, .uopTagA, .uopSrcB, .uopTagB, .stall,
        .resultValid, .resultTag, .resultData
    );

    `include "tbTasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================
    // Assertions
    // ==================================================

    assert property (@(posedge clk) disable iff (rst)
            !firstAccepted |-> (!stall && resultValid == '0))
        else begin
            protocolErrors++;
            $display("Stall or a result bus was active before any micro-op was accepted");
        end

    // Every station slot and the dispatcher register hold a micro-op.
    assert property (@(posedge clk) disable iff (rst)
            stall |-> inFlight >= STATION_COUNT * QUEUE_SIZE + 1)
        else begin
            protocolErrors++;
            $display("Stall was high while a station still had room");
        end

    always @(posedge clk) begin
        logic [TAG_WIDTH-1:0] t;
        if (!rst) begin
            if (stall) stallSeen = 1'b1;
            for (int b = 0; b < RESULT_BUS_COUNT; b++) begin
                if (resultValid[b]) begin
                    t = resultTag[b];
                    for (int c = b + 1; c < RESULT_BUS_COUNT; c++) begin
                        assert (!(resultValid[c] && resultTag[c] == t)) else begin
                            protocolErrors++;
                            $display("Tag %0d appeared on two result buses at once", t);
                        end
                    end
                    assert (tagState[t] == TAG_PENDING) else begin
                        protocolErrors++;
                        $display("Result for tag %0d that was not outstanding", t);
                    end
                    assert (resultData[b] == expValue[t]) else begin
                        valueErrors++;
                        $display("CHECK FAILED resultData[%0d] tag 0x%h: got 0x%h, expected 0x%h",
                                 b, t, resultData[b], expValue[t]);
                    end
                    if (timedTag[t]) begin
                        assert (cycleCount == acceptCycle[t] + 4) else begin
                            valueErrors++;
                            $display("CHECK FAILED resultValid latency tag 0x%h: got 0x%h, expected 0x%h",
                                     t, cycleCount - acceptCycle[t], 4);
                        end
                    end
                    tagState[t] = TAG_DONE;
                    inFlight--;
                end
            end
            if (uopValid && !stall) begin    // Acceptance edge.
                tagState[uopTagDst] = TAG_PENDING;
                acceptCycle[uopTagDst] = cycleCount;
                inFlight++;
                firstAccepted = 1'b1;
            end
        end
        cycleCount++;
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        logic [TAG_WIDTH-1:0] tag;
        logic [TAG_WIDTH-1:0] prev;
        logic [TAG_WIDTH-1:0] srcA;
        logic [TAG_WIDTH-1:0] srcB;
        logic [TAG_WIDTH-1:0] recent [8];
        void'($urandom(32'h45ba_5bd5));
        rst = 1'b1;
        uopValid = 1'b0;
        uopOpcode = ALU_ADD;
        uopTagDst = '0;
        uopImm = '0;
        uopSrcA = '0;
        uopTagA = '0;
        uopSrcB = '0;
        uopTagB = '0;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;
        idleCycles(4);

        // Every opcode alone in an idle cluster, timed.
        for (int i = 0; i < 8; i++) begin
            sendUop(AluOp'(i), '0, $urandom(), '0, $urandom(), 1'b1, tag);
            waitForTag(tag);
        end

        // Consumers right behind their producer.
        sendUop(ALU_ADD, '0, $urandom(), '0, $urandom(), 1'b0, prev);
        sendUop(ALU_SUB, prev, '0, '0, $urandom(), 1'b0, tag);
        sendUop(ALU_XOR, tag, '0, prev, '0, 1'b0, tag);
        waitDrained();

        // Slow dependency chain, then a burst waiting on its tail.
        sendUop(ALU_ADD, '0, $urandom(), '0, $urandom(), 1'b0, prev);
        for (int i = 1; i < 10; i++) begin
            sendUop(AluOp'($urandom_range(0, 4)), prev, '0, '0, $urandom(), 1'b0, prev);
        end
        stallSeen = 1'b0;
        for (int i = 0; i < 18; i++) begin
            sendUop(AluOp'($urandom_range(0, 6)), prev, '0, '0, $urandom(), 1'b0, tag);
        end
        assert (stallSeen) else begin
            protocolErrors++;
            $display("Stall never rose during the dependent burst");
        end
        waitDrained();

        // Random mix with dependencies on recent tags.
        for (int i = 0; i < 8; i++) begin
            recent[i] = '0;
        end
        for (int i = 0; i < 40; i++) begin
            srcA = ($urandom_range(0, 1) == 1) ? recent[$urandom_range(0, 7)] : '0;
            srcB = ($urandom_range(0, 1) == 1) ? recent[$urandom_range(0, 7)] : '0;
            sendUop(AluOp'($urandom_range(0, 7)), srcA, $urandom(), srcB, $urandom(), 1'b0, tag);
            recent[i % 8] = tag;
        end
        waitDrained();
        idleCycles(5);

        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+dv
common/cfgPkg.sv
common/uopPkg.sv
design/Dispatcher.sv
reservationStation/ReservationStation.sv
design/IntAlu.sv
design/ResultArbiter.sv
design/ExecCluster.sv
dv/ExecClusterTb.sv

// ==== reservationStation/ReservationStation.sv ====
`timescale 1ns/10ps

module ReservationStation #(
    parameter int QUEUE_SIZE = 4,
    parameter int RESULT_BUS_COUNT = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic enqValid,
    input  logic enqSelected,
    input  uopPkg::AluOp enqOpcode,
    input  logic [cfgPkg::TAG_WIDTH-1:0] enqTagDst,
    input  logic [cfgPkg::DATA_WIDTH-1:0] enqImm,
    input  logic [cfgPkg::DATA_WIDTH-1:0] enqSrcA,
    input  logic [cfgPkg::TAG_WIDTH-1:0] enqTagA,
    input  logic [cfgPkg::DATA_WIDTH-1:0] enqSrcB,
    input  logic [cfgPkg::TAG_WIDTH-1:0] enqTagB,

    input  logic [RESULT_BUS_COUNT-1:0] resultValid,
    input  logic [cfgPkg::TAG_WIDTH-1:0] resultTag [RESULT_BUS_COUNT],
    input  logic [cfgPkg::DATA_WIDTH-1:0] resultData [RESULT_BUS_COUNT],

    input  logic aluBusy,

    output logic full,
    output logic issueValid,
    output uopPkg::AluOp issueOpcode,
    output logic [cfgPkg::DATA_WIDTH-1:0] issueA,
    output logic [cfgPkg::DATA_WIDTH-1:0] issueB,
    output logic [cfgPkg::DATA_WIDTH-1:0] issueImm,
    output logic [cfgPkg::TAG_WIDTH-1:0] issueTagDst
);
    import cfgPkg::*;
    import uopPkg::*;

    localparam int IDX_WIDTH = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

    StationEntry queue [QUEUE_SIZE];
    StationEntry newEntry;
    logic [QUEUE_SIZE-1:0] slotReady;
    logic [IDX_WIDTH-1:0] issueIdx;
    logic [IDX_WIDTH-1:0] freeIdx;
    logic doIssue;

    // ==================================================
    // Slot selection
    // ==================================================

    always_comb begin
        full = 1'b1;
        issueIdx = '0;
        freeIdx = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            slotReady[i] = queue[i].valid && (queue[i].srcTag == '0);
            if (slotReady[i]) issueIdx = IDX_WIDTH'(i);    // Lowest index wins.
            if (!queue[i].valid) begin
                freeIdx = IDX_WIDTH'(i);
                full = 1'b0;
            end
        end
    end

    assign doIssue = !aluBusy && (|slotReady);

    always_comb begin
        newEntry.valid = 1'b1;
        newEntry.opcode = enqOpcode;
        newEntry.tagDst = enqTagDst;
        newEntry.imm = enqImm;
        newEntry.srcVal[SRC_A] = enqSrcA;
        newEntry.srcVal[SRC_B] = enqSrcB;
        newEntry.srcTag[SRC_A] = enqTagA;
        newEntry.srcTag[SRC_B] = enqTagB;
    end

    // ==================================================
    // Queue update
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                queue[i].valid <= 1'b0;
            end
            issueValid <= 1'b0;
        end else begin
            // Wakeup from the result buses.
            for (int j = 0; j < QUEUE_SIZE; j++) begin
                for (int s = 0; s < SRC_COUNT; s++) begin
                    for (int b = 0; b < RESULT_BUS_COUNT; b++) begin
                        if (queue[j].srcTag[s] != TAG_READY && resultValid[b]
                                && queue[j].srcTag[s] == resultTag[b]) begin
                            queue[j].srcTag[s] <= TAG_READY;
                            queue[j].srcVal[s] <= resultData[b];
                        end
                    end
                end
            end

            if (!aluBusy) issueValid <= doIssue;    // Hold while the ALU is stuck.
            if (doIssue) queue[issueIdx].valid <= 1'b0;

            // The dispatcher only selects us when a slot is free.
            if (enqValid && enqSelected) queue[freeIdx] <= newEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (doIssue) begin
            issueOpcode <= queue[issueIdx].opcode;
            issueA <= queue[issueIdx].srcVal[SRC_A];
            issueB <= queue[issueIdx].srcVal[SRC_B];
            issueImm <= queue[issueIdx].imm;
            issueTagDst <= queue[issueIdx].tagDst;
        end
    end

endmodule
